//--- cpu65_config.svh
`ifndef CPU65_CONFIG_SVH
`define CPU65_CONFIG_SVH

// Bus widths
`define ADDR_W 16
`define BYTE_W 8

// Pointer values after reset
`define PC_RESET 16'h0400
`define S_RESET 16'h01FF // Top of S page
`define R_RESET 16'h0300

`endif

//--- cpu65_pkg.sv
`default_nettype none

package cpu65_pkg;

	// Kept addressing modes
	typedef enum logic [4:0] {
		ModeImm,
		ModeZp,
		ModeZpX,
		ModeZpY,
		ModeAbs,
		ModeAbsX,
		ModeAbsY,
		ModeInd,
		ModeIndX,
		ModeIndY,
		ModeSStack,
		ModeRStack,
		ModePhz,  // Push on S
		ModePlz,  // Pull from S
		ModeRhz,  // Push on R
		ModeRlz   // Pull from R
	} addrMode_t;

	// One access per step
	typedef enum logic [2:0] {
		StepIdle,
		StepAddrL,
		StepAddrH,
		StepIndrL,
		StepIndrH,
		StepValL,
		StepValH
	} seqStep_t;

	typedef enum logic [2:0] {
		BasePc,
		BaseS,
		BaseR,
		BaseAddr,
		BaseIndr
	} baseSel_t;

	typedef enum logic [1:0] {
		AddNone,
		AddX,
		AddY,
		AddAddr
	} addSel_t;

	// AddOne only offsets the address while Inc and PreDec move the pointer
	typedef enum logic [1:0] {
		IncDecNone,
		IncDecAddOne,
		IncDecPreDec,
		IncDecInc
	} incDec_t;

endpackage

`default_nettype wire

//--- addrSeqFsm.sv
`default_nettype none
`timescale 1ns/100ps

module addrSeqFsm (
	input wire logic Clock,
	input wire logic rst,
	input wire logic start,
	input wire cpu65_pkg::addrMode_t mode,
	input wire logic dataSize,
	input wire logic write,
	output cpu65_pkg::seqStep_t step,
	output cpu65_pkg::baseSel_t baseSel,
	output cpu65_pkg::addSel_t addSel,
	output cpu65_pkg::incDec_t incDec,
	output logic pageWrap,
	output logic highByte,
	output logic memRead,
	output logic memWrite,
	output logic busy,
	output logic done
);

	cpu65_pkg::addrMode_t modeReg;
	cpu65_pkg::seqStep_t stepNext;
	logic sizeReg;
	logic writeReg;

	// Sequence table giving the next step for a mode at a given step
	function automatic cpu65_pkg::seqStep_t seqNext(input cpu65_pkg::addrMode_t m,
			input logic sz, input cpu65_pkg::seqStep_t st);
		logic absMode;
		logic indMode;
		logic pushMode;
		absMode = m inside {cpu65_pkg::ModeAbs, cpu65_pkg::ModeAbsX, cpu65_pkg::ModeAbsY};
		indMode = m inside {cpu65_pkg::ModeInd, cpu65_pkg::ModeIndX, cpu65_pkg::ModeIndY};
		pushMode = m inside {cpu65_pkg::ModePhz, cpu65_pkg::ModeRhz};
		case (st)
			cpu65_pkg::StepIdle: begin
				if (pushMode)
					seqNext = sz ? cpu65_pkg::StepValH : cpu65_pkg::StepValL; // High byte first
				else if (m inside {cpu65_pkg::ModeImm, cpu65_pkg::ModePlz, cpu65_pkg::ModeRlz})
					seqNext = cpu65_pkg::StepValL;
				else
					seqNext = cpu65_pkg::StepAddrL;
			end
			cpu65_pkg::StepAddrL: begin
				if (absMode)
					seqNext = cpu65_pkg::StepAddrH;
				else if (indMode)
					seqNext = cpu65_pkg::StepIndrL;
				else
					seqNext = cpu65_pkg::StepValL;
			end
			cpu65_pkg::StepAddrH: seqNext = cpu65_pkg::StepValL;
			cpu65_pkg::StepIndrL: seqNext = cpu65_pkg::StepIndrH;
			cpu65_pkg::StepIndrH: seqNext = cpu65_pkg::StepValL;
			cpu65_pkg::StepValL:
				seqNext = (sz && !pushMode) ? cpu65_pkg::StepValH : cpu65_pkg::StepIdle;
			cpu65_pkg::StepValH: seqNext = pushMode ? cpu65_pkg::StepValL : cpu65_pkg::StepIdle;
			default: seqNext = cpu65_pkg::StepIdle;
		endcase
	endfunction

	always_comb begin
		if (step == cpu65_pkg::StepIdle)
			stepNext = start ? seqNext(mode, dataSize, cpu65_pkg::StepIdle) : cpu65_pkg::StepIdle;
		else
			stepNext = seqNext(modeReg, sizeReg, step);
	end

	assign busy = (step != cpu65_pkg::StepIdle);
	assign done = busy && (stepNext == cpu65_pkg::StepIdle);

	always_ff @(posedge Clock) begin
		if (rst) begin
			step <= cpu65_pkg::StepIdle;
			modeReg <= cpu65_pkg::ModeImm;
			sizeReg <= 1'b0;
			writeReg <= 1'b0;
		end else begin
			step <= stepNext;
			if (step == cpu65_pkg::StepIdle && start) begin // Latch the request
				modeReg <= mode;
				sizeReg <= dataSize;
				writeReg <= write;
			end
		end
	end

	// Control fields of the current step
	always_comb begin
		baseSel = cpu65_pkg::BasePc;
		addSel = cpu65_pkg::AddNone;
		incDec = cpu65_pkg::IncDecNone;
		pageWrap = 1'b0;
		highByte = (step == cpu65_pkg::StepValH);
		memRead = 1'b0;
		memWrite = 1'b0;
		case (step)
			cpu65_pkg::StepAddrL, cpu65_pkg::StepAddrH: begin
				incDec = cpu65_pkg::IncDecInc;
				memRead = 1'b1;
			end
			cpu65_pkg::StepIndrL, cpu65_pkg::StepIndrH: begin
				baseSel = cpu65_pkg::BaseAddr;
				if (modeReg == cpu65_pkg::ModeIndX)
					addSel = cpu65_pkg::AddX;
				if (step == cpu65_pkg::StepIndrH)
					incDec = cpu65_pkg::IncDecAddOne;
				pageWrap = 1'b1; // Pointer stays in page 0
				memRead = 1'b1;
			end
			cpu65_pkg::StepValL, cpu65_pkg::StepValH: begin
				if (highByte)
					incDec = cpu65_pkg::IncDecAddOne;
				memRead = !writeReg;
				memWrite = writeReg;
				case (modeReg)
					cpu65_pkg::ModeImm: begin
						incDec = cpu65_pkg::IncDecInc;
						memRead = 1'b1;
						memWrite = 1'b0;
					end
					cpu65_pkg::ModeZp, cpu65_pkg::ModeZpX, cpu65_pkg::ModeZpY: begin
						baseSel = cpu65_pkg::BaseAddr;
						pageWrap = 1'b1;
						if (modeReg == cpu65_pkg::ModeZpX)
							addSel = cpu65_pkg::AddX;
						else if (modeReg == cpu65_pkg::ModeZpY)
							addSel = cpu65_pkg::AddY;
					end
					cpu65_pkg::ModeAbs: baseSel = cpu65_pkg::BaseAddr;
					cpu65_pkg::ModeAbsX: begin
						baseSel = cpu65_pkg::BaseAddr;
						addSel = cpu65_pkg::AddX;
					end
					cpu65_pkg::ModeAbsY: begin
						baseSel = cpu65_pkg::BaseAddr;
						addSel = cpu65_pkg::AddY;
					end
					cpu65_pkg::ModeInd, cpu65_pkg::ModeIndX: baseSel = cpu65_pkg::BaseIndr;
					cpu65_pkg::ModeIndY: begin
						baseSel = cpu65_pkg::BaseIndr;
						addSel = cpu65_pkg::AddY;
					end
					cpu65_pkg::ModeSStack, cpu65_pkg::ModeRStack: begin
						baseSel = (modeReg == cpu65_pkg::ModeSStack) ?
							cpu65_pkg::BaseS : cpu65_pkg::BaseR;
						addSel = cpu65_pkg::AddAddr; // Offset from operand byte
					end
					cpu65_pkg::ModePhz, cpu65_pkg::ModeRhz: begin
						baseSel = (modeReg == cpu65_pkg::ModePhz) ?
							cpu65_pkg::BaseS : cpu65_pkg::BaseR;
						incDec = cpu65_pkg::IncDecPreDec;
						memRead = 1'b0;
						memWrite = 1'b1;
					end
					default: begin // Pulls
						baseSel = (modeReg == cpu65_pkg::ModePlz) ?
							cpu65_pkg::BaseS : cpu65_pkg::BaseR;
						incDec = cpu65_pkg::IncDecInc;
						memRead = 1'b1;
						memWrite = 1'b0;
					end
				endcase
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- ptrCounter.sv
`default_nettype none
`timescale 1ns/100ps
`include "cpu65_config.svh"

module ptrCounter (
	input wire logic Clock,
	input wire logic rst,
	input wire cpu65_pkg::seqStep_t step,
	input wire cpu65_pkg::baseSel_t baseSel,
	input wire cpu65_pkg::incDec_t incDec,
	output logic [`ADDR_W-1:0] pc,
	output logic [`ADDR_W-1:0] s,
	output logic [`ADDR_W-1:0] r
);

	logic [`ADDR_W-1:0] ptrCur;
	logic [`ADDR_W-1:0] ptrNext;
	logic ptrMove;

	always_comb begin
		case (baseSel)
			cpu65_pkg::BaseS: ptrCur = s;
			cpu65_pkg::BaseR: ptrCur = r;
			default: ptrCur = pc;
		endcase
	end

	// Same value a push addresses in this cycle
	assign ptrNext = (incDec == cpu65_pkg::IncDecPreDec) ? ptrCur - 1'b1 : ptrCur + 1'b1;

	assign ptrMove = (step != cpu65_pkg::StepIdle) &&
		(incDec == cpu65_pkg::IncDecInc || incDec == cpu65_pkg::IncDecPreDec);

	always_ff @(posedge Clock) begin
		if (rst) begin
			pc <= `PC_RESET;
			s <= `S_RESET;
			r <= `R_RESET;
		end else if (ptrMove) begin
			case (baseSel)
				cpu65_pkg::BasePc: pc <= ptrNext;
				cpu65_pkg::BaseS: s <= ptrNext;
				cpu65_pkg::BaseR: r <= ptrNext;
				default: ; // Operand registers never move
			endcase
		end
	end

endmodule

`default_nettype wire

//--- operandRegs.sv
`default_nettype none
`timescale 1ns/100ps
`include "cpu65_config.svh"

module operandRegs (
	input wire logic Clock,
	input wire logic rst,
	input wire cpu65_pkg::seqStep_t step,
	input wire logic [`BYTE_W-1:0] memData,
	output logic [`ADDR_W-1:0] operandAddr,
	output logic [`ADDR_W-1:0] indrAddr,
	output logic [2*`BYTE_W-1:0] value
);

	localparam int HighW = `ADDR_W - `BYTE_W;

	always_ff @(posedge Clock) begin
		if (rst) begin
			operandAddr <= '0;
			indrAddr <= '0;
			value <= '0;
		end else begin
			case (step)
				// Zero page and stack offsets are single bytes
				cpu65_pkg::StepAddrL: operandAddr <= {{HighW{1'b0}}, memData};
				cpu65_pkg::StepAddrH: operandAddr[`ADDR_W-1:`BYTE_W] <= memData;
				cpu65_pkg::StepIndrL: indrAddr[`BYTE_W-1:0] <= memData;
				cpu65_pkg::StepIndrH: indrAddr[`ADDR_W-1:`BYTE_W] <= memData;
				cpu65_pkg::StepValL: value <= {{`BYTE_W{1'b0}}, memData}; // 8-bit result
				cpu65_pkg::StepValH: value[2*`BYTE_W-1:`BYTE_W] <= memData;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- addrCalc.sv
`default_nettype none
`timescale 1ns/100ps
`include "cpu65_config.svh"

module addrCalc (
	input wire cpu65_pkg::baseSel_t baseSel,
	input wire cpu65_pkg::addSel_t addSel,
	input wire cpu65_pkg::incDec_t incDec,
	input wire logic pageWrap,
	input wire logic highByte,
	input wire logic [`ADDR_W-1:0] pc,
	input wire logic [`ADDR_W-1:0] s,
	input wire logic [`ADDR_W-1:0] r,
	input wire logic [`ADDR_W-1:0] operandAddr,
	input wire logic [`ADDR_W-1:0] indrAddr,
	input wire logic [`ADDR_W-1:0] x,
	input wire logic [`ADDR_W-1:0] y,
	input wire logic [2*`BYTE_W-1:0] wrData,
	output logic [`ADDR_W-1:0] address,
	output logic [`BYTE_W-1:0] memWrData
);

	logic [`ADDR_W-1:0] base;
	logic [`ADDR_W-1:0] index;
	logic [`ADDR_W-1:0] offset;
	logic [`ADDR_W-1:0] sum;

	always_comb begin
		case (baseSel)
			cpu65_pkg::BaseS: base = s;
			cpu65_pkg::BaseR: base = r;
			cpu65_pkg::BaseAddr: base = operandAddr;
			cpu65_pkg::BaseIndr: base = indrAddr;
			default: base = pc;
		endcase
	end

	always_comb begin
		case (addSel)
			cpu65_pkg::AddX: index = x;
			cpu65_pkg::AddY: index = y;
			cpu65_pkg::AddAddr: index = operandAddr;
			default: index = '0;
		endcase
	end

	// Push addresses the slot below the pointer
	always_comb begin
		case (incDec)
			cpu65_pkg::IncDecAddOne: offset = `ADDR_W'(1);
			cpu65_pkg::IncDecPreDec: offset = '1;
			default: offset = '0;
		endcase
	end

	assign sum = base + index + offset;

	assign address = pageWrap ? {{(`ADDR_W-`BYTE_W){1'b0}}, sum[`BYTE_W-1:0]} : sum;

	assign memWrData = highByte ? wrData[2*`BYTE_W-1:`BYTE_W] : wrData[`BYTE_W-1:0];

endmodule

`default_nettype wire

//--- cpu65AddrSeq.sv
`default_nettype none
`timescale 1ns/100ps
`include "cpu65_config.svh"

module cpu65AddrSeq (
	input wire logic Clock,
	input wire logic rst,
	input wire logic start,
	input wire cpu65_pkg::addrMode_t mode,
	input wire logic dataSize,
	input wire logic write,
	input wire logic [2*`BYTE_W-1:0] wrData,
	input wire logic [`ADDR_W-1:0] x,
	input wire logic [`ADDR_W-1:0] y,
	input wire logic [`BYTE_W-1:0] memData,
	output logic [`ADDR_W-1:0] address,
	output logic memRead,
	output logic memWrite,
	output logic [`BYTE_W-1:0] memWrData,
	output logic busy,
	output logic done,
	output logic [2*`BYTE_W-1:0] value,
	output logic [`ADDR_W-1:0] pc,
	output logic [`ADDR_W-1:0] s,
	output logic [`ADDR_W-1:0] r
);

	cpu65_pkg::seqStep_t step;
	cpu65_pkg::baseSel_t baseSel;
	cpu65_pkg::addSel_t addSel;
	cpu65_pkg::incDec_t incDec;
	logic pageWrap;
	logic highByte;
	logic [`ADDR_W-1:0] operandAddr;
	logic [`ADDR_W-1:0] indrAddr;

	addrSeqFsm fsm (
		.Clock(Clock), .rst(rst), .start(start), .mode(mode),
		.dataSize(dataSize), .write(write), .step(step), .baseSel(baseSel),
		.addSel(addSel), .incDec(incDec), .pageWrap(pageWrap), .highByte(highByte),
		.memRead(memRead), .memWrite(memWrite), .busy(busy), .done(done)
	);

	ptrCounter ptrs (
		.Clock(Clock), .rst(rst), .step(step), .baseSel(baseSel),
		.incDec(incDec), .pc(pc), .s(s), .r(r)
	);

	// Operand, pointer and value bytes from memory
	operandRegs opRegs (
		.Clock(Clock), .rst(rst), .step(step), .memData(memData),
		.operandAddr(operandAddr), .indrAddr(indrAddr), .value(value)
	);

	addrCalc calc (
		.baseSel(baseSel), .addSel(addSel), .incDec(incDec), .pageWrap(pageWrap),
		.highByte(highByte), .pc(pc), .s(s), .r(r),
		.operandAddr(operandAddr), .indrAddr(indrAddr), .x(x), .y(y),
		.wrData(wrData), .address(address), .memWrData(memWrData)
	);

endmodule

`default_nettype wire

//--- tbClock.sv
`default_nettype none
`timescale 1ns/100ps

module tbClock (
	output logic Clock
);

	localparam real HalfPeriod = 20.0; // 40 ns period

	initial Clock = 1'b0;

	always #(HalfPeriod) Clock = ~Clock;

endmodule

`default_nettype wire

//--- cpu65AddrSeq_assert.sv
`default_nettype none
`timescale 1ns/100ps

module cpu65AddrSeq_assert (
	input wire logic Clock,
	input wire logic rst,
	input wire logic busy,
	input wire logic done,
	input wire logic memRead,
	input wire logic memWrite
);

	int failCount = 0;

	assert property (@(posedge Clock) disable iff (rst) !(memRead && memWrite))
	else begin
		failCount++;
		$error("memRead and memWrite are high together");
	end

	assert property (@(posedge Clock) disable iff (rst) done |-> busy)
	else begin
		failCount++;
		$error("done is high while not busy");
	end

	// Bus is quiet between operations
	assert property (@(posedge Clock) disable iff (rst) (memRead || memWrite) |-> busy)
	else begin
		failCount++;
		$error("memory access while not busy");
	end

endmodule

`default_nettype wire

//--- tbCpu65AddrSeq.sv
`default_nettype none
`timescale 1ns/100ps
`include "cpu65_config.svh"

module tbCpu65AddrSeq;

	localparam int NumOps = 300;
	localparam int TimeoutCycles = NumOps * 8 + 20;

	logic Clock;
	logic rst;
	logic start;
	cpu65_pkg::addrMode_t mode;
	logic dataSize;
	logic write;
	logic [15:0] wrData;
	logic [15:0] x;
	logic [15:0] y;
	logic [7:0] memData;
	logic [15:0] address;
	logic memRead;
	logic memWrite;
	logic [7:0] memWrData;
	logic busy;
	logic done;
	logic [15:0] value;
	logic [15:0] pc;
	logic [15:0] s;
	logic [15:0] r;

	logic [7:0] mem [0:65535];
	logic [31:0] lfsr;
	int cycles = 0;

	// Reference model state
	logic [15:0] pcM;
	logic [15:0] sM;
	logic [15:0] rM;
	logic [15:0] expAddr [0:7];
	logic expWr [0:7];
	logic [7:0] expData [0:7];
	int expN;
	logic [15:0] expValue;
	logic expRead;

	tbClock clkGen (.Clock(Clock));

	cpu65AddrSeq dut (
		.Clock(Clock), .rst(rst), .start(start), .mode(mode), .dataSize(dataSize),
		.write(write), .wrData(wrData), .x(x), .y(y), .memData(memData),
		.address(address), .memRead(memRead), .memWrite(memWrite), .memWrData(memWrData),
		.busy(busy), .done(done), .value(value), .pc(pc), .s(s), .r(r)
	);

	bind cpu65AddrSeq cpu65AddrSeq_assert chk (
		.Clock(Clock), .rst(rst), .busy(busy), .done(done),
		.memRead(memRead), .memWrite(memWrite)
	);

	assign memData = mem[address]; // Same-cycle read

	always @(posedge Clock) begin
		if (memWrite)
			mem[address] <= memWrData;
	end

	always @(posedge Clock) begin
		cycles <= cycles + 1;
		if (cycles >= TimeoutCycles) begin
			$display("Timeout: the run did not end within %0d cycles", TimeoutCycles);
			$display("TEST FAIL");
			$fatal(1, "run stopped on timeout");
		end else if (dut.chk.failCount != 0) begin
			$display("A bound assertion on the control outputs failed");
			$display("TEST FAIL");
			$fatal(1, "run stopped on assertion failure");
		end
	end

	// Taps 32, 22, 2, 1
	function automatic logic nextBit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [15:0] randBits(input int width);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < width; i++)
			v = {v[14:0], nextBit()};
		return v;
	endfunction

	function automatic cpu65_pkg::addrMode_t randMode();
		logic [15:0] v;
		v = randBits(4);
		return cpu65_pkg::addrMode_t'(v[4:0]);
	endfunction

	task automatic checkVal(input string name, input logic [31:0] expVal,
			input logic [31:0] gotVal);
		if (gotVal !== expVal) begin
			$display("[FAIL] %s expected %h got %h", name, expVal, gotVal);
			$display("TEST FAIL");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic addAccess(input logic [15:0] a, input logic wr, input logic [7:0] d);
		expAddr[expN] = a;
		expWr[expN] = wr;
		expData[expN] = d;
		expN++;
	endtask

	// Expected accesses, value and pointers from the address rules
	task automatic buildModel(input cpu65_pkg::addrMode_t m, input logic sz, input logic wr,
			input logic [15:0] xv, input logic [15:0] yv, input logic [15:0] wd);
		logic [15:0] oper;
		logic [15:0] indr;
		logic [15:0] ea;
		logic [15:0] sp;
		logic [7:0] zp;
		logic [7:0] lo;
		logic [7:0] hi;
		logic isPush;
		logic isPull;
		logic isZp;
		expN = 0;
		oper = '0;
		indr = '0;
		hi = 8'h00;
		isPush = m inside {cpu65_pkg::ModePhz, cpu65_pkg::ModeRhz};
		isPull = m inside {cpu65_pkg::ModePlz, cpu65_pkg::ModeRlz};
		isZp = m inside {cpu65_pkg::ModeZp, cpu65_pkg::ModeZpX, cpu65_pkg::ModeZpY};
		sp = (m inside {cpu65_pkg::ModePhz, cpu65_pkg::ModePlz}) ? sM : rM;
		expRead = (m == cpu65_pkg::ModeImm) || isPull || (!isPush && !wr);
		if (!(isPush || isPull || m == cpu65_pkg::ModeImm)) begin
			addAccess(pcM, 1'b0, 8'h00);
			oper[7:0] = mem[pcM];
			pcM++;
			if (m inside {cpu65_pkg::ModeAbs, cpu65_pkg::ModeAbsX, cpu65_pkg::ModeAbsY}) begin
				addAccess(pcM, 1'b0, 8'h00);
				oper[15:8] = mem[pcM];
				pcM++;
			end
		end
		if (m inside {cpu65_pkg::ModeInd, cpu65_pkg::ModeIndX, cpu65_pkg::ModeIndY}) begin
			zp = oper[7:0] + ((m == cpu65_pkg::ModeIndX) ? xv[7:0] : 8'h00);
			addAccess({8'h00, zp}, 1'b0, 8'h00);
			indr[7:0] = mem[{8'h00, zp}];
			zp = zp + 8'h01; // Pointer wraps in page 0
			addAccess({8'h00, zp}, 1'b0, 8'h00);
			indr[15:8] = mem[{8'h00, zp}];
		end
		zp = oper[7:0] + ((m == cpu65_pkg::ModeZpX) ? xv[7:0] :
			(m == cpu65_pkg::ModeZpY) ? yv[7:0] : 8'h00);
		case (m)
			cpu65_pkg::ModeAbs: ea = oper;
			cpu65_pkg::ModeAbsX: ea = oper + xv;
			cpu65_pkg::ModeAbsY: ea = oper + yv;
			cpu65_pkg::ModeInd, cpu65_pkg::ModeIndX: ea = indr;
			cpu65_pkg::ModeIndY: ea = indr + yv;
			cpu65_pkg::ModeSStack: ea = sM + oper;
			cpu65_pkg::ModeRStack: ea = rM + oper;
			default: ea = {8'h00, zp};
		endcase
		if (m == cpu65_pkg::ModeImm) begin
			lo = mem[pcM];
			addAccess(pcM, 1'b0, 8'h00);
			pcM++;
			if (sz) begin
				hi = mem[pcM];
				addAccess(pcM, 1'b0, 8'h00);
				pcM++;
			end
		end else if (isPush) begin
			lo = 8'h00;
			if (sz) begin
				sp--;
				addAccess(sp, 1'b1, wd[15:8]); // High byte first
			end
			sp--;
			addAccess(sp, 1'b1, wd[7:0]);
		end else if (isPull) begin
			lo = mem[sp];
			addAccess(sp, 1'b0, 8'h00);
			sp++;
			if (sz) begin
				hi = mem[sp];
				addAccess(sp, 1'b0, 8'h00);
				sp++;
			end
		end else begin
			lo = mem[ea];
			addAccess(ea, wr, wd[7:0]);
			if (sz) begin
				zp = zp + 8'h01;
				ea = isZp ? {8'h00, zp} : ea + 16'h0001;
				hi = mem[ea];
				addAccess(ea, wr, wd[15:8]);
			end
		end
		if (m inside {cpu65_pkg::ModePhz, cpu65_pkg::ModePlz})
			sM = sp;
		else if (m inside {cpu65_pkg::ModeRhz, cpu65_pkg::ModeRlz})
			rM = sp;
		expValue = {hi, lo};
	endtask

	task automatic runOp();
		cpu65_pkg::addrMode_t m;
		logic [15:0] xv;
		logic [15:0] yv;
		logic [15:0] wd;
		logic sz;
		logic wr;
		logic extra;
		logic gotDone;
		int idx;
		m = randMode();
		sz = nextBit();
		wr = nextBit();
		xv = randBits(16);
		yv = randBits(16);
		wd = randBits(16);
		extra = nextBit();
		buildModel(m, sz, wr, xv, yv, wd);
		start = 1'b1;
		mode = m;
		dataSize = sz;
		write = wr;
		x = xv;
		y = yv;
		wrData = wd;
		@(posedge Clock);
		@(negedge Clock);
		start = 1'b0;
		if (extra) begin
			start = 1'b1; // Must be ignored while busy
			mode = randMode();
			dataSize = nextBit();
			write = nextBit();
		end
		idx = 0;
		gotDone = 1'b0;
		while (!gotDone) begin
			checkVal("busy", 1, busy);
			checkVal("address", expAddr[idx], address);
			checkVal("memWrite", expWr[idx], memWrite);
			checkVal("memRead", !expWr[idx], memRead);
			if (expWr[idx])
				checkVal("memWrData", expData[idx], memWrData);
			checkVal("done", idx == expN - 1, done);
			gotDone = done;
			@(posedge Clock);
			@(negedge Clock);
			start = 1'b0;
			idx++;
		end
		checkVal("busy", 0, busy);
		checkVal("done", 0, done);
		checkVal("pc", pcM, pc);
		checkVal("s", sM, s);
		checkVal("r", rM, r);
		if (expRead)
			checkVal("value", expValue, value);
	endtask

	initial begin
		logic [15:0] rv;
		rst = 1'b1;
		start = 1'b0;
		mode = cpu65_pkg::ModeImm;
		dataSize = 1'b0;
		write = 1'b0;
		wrData = '0;
		x = '0;
		y = '0;
		lfsr = 32'd85349;
		for (int a = 0; a < 65536; a++) begin
			rv = randBits(8);
			mem[a] <= rv[7:0];
		end
		pcM = `PC_RESET;
		sM = `S_RESET;
		rM = `R_RESET;
		repeat (2) @(posedge Clock);
		@(negedge Clock);
		rst = 1'b0;
		checkVal("busy", 0, busy);
		checkVal("done", 0, done);
		checkVal("memRead", 0, memRead);
		checkVal("memWrite", 0, memWrite);
		checkVal("pc", `PC_RESET, pc);
		checkVal("s", `S_RESET, s);
		checkVal("r", `R_RESET, r);
		for (int n = 0; n < NumOps; n++)
			runOp();
		if (dut.chk.failCount != 0) begin
			$display("TEST FAIL");
			$fatal(1, "assertion failures were seen");
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
cpu65_pkg.sv
addrSeqFsm.sv
ptrCounter.sv
operandRegs.sv
addrCalc.sv
cpu65AddrSeq.sv
tbClock.sv
cpu65AddrSeq_assert.sv
tbCpu65AddrSeq.sv
